//--- Makefile
# Verilator build of the testbench, rebuilt only when a source changes

obj_dir/Vtb_cariboulite_top: cariboulite_top.f $(wildcard hw/*.sv tb/*.sv)
	verilator --binary --timing --assert -sv --top-module tb_cariboulite_top \
		-f cariboulite_top.f -o Vtb_cariboulite_top

run: obj_dir/Vtb_cariboulite_top
	-./obj_dir/Vtb_cariboulite_top | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- cariboulite_top.f
hw/cariboulite_pkg.sv
hw/reg_bus_if.sv
hw/reg_bus_mux.sv
hw/sys_ctrl.sv
hw/io_ctrl.sv
hw/rx_sample_fifo.sv
hw/smi_rx_reader.sv
hw/cariboulite_top.sv
tb/tb_cariboulite_top.sv

//--- hw/cariboulite_pkg.sv
`default_nettype none

package cariboulite_pkg;

  // ==========================================================================
  // Command bus
  // ==========================================================================
  localparam int CMD_ADDR_W = 5;           // Register address bits
  localparam int CMD_DATA_W = 8;           // One command byte
  localparam int NUM_PEERS  = 4;           // One-hot select lines, bit 3 reserved

  typedef logic [CMD_DATA_W-1:0] cmd_data_t;
  typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;

  // Receive sample as delivered by the modem, I in the upper half
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } sample_t;

  // RF front-end mode, codes 5 to 7 unused
  typedef enum logic [2:0] {
    LOW_POWER = 3'd0,
    RX_09     = 3'd1,
    TX_09     = 3'd2,
    RX_24     = 3'd3,
    TX_24     = 3'd4
  } rf_mode_e;

  // ==========================================================================
  // Sample buffering and readout
  // ==========================================================================
  localparam int FIFO_DEPTH       = 16;    // Samples held in the RX FIFO
  localparam int BYTES_PER_SAMPLE = 4;     // Sent MSB first on the SMI port

  localparam cmd_data_t FW_VERSION     = 8'h01;
  localparam cmd_data_t RESERVED_RDATA = 8'hA5;  // Answer for select line 3 alone

  // Register map per peer
  localparam cmd_addr_t SYS_VERSION_ADDR = 5'd0;
  localparam cmd_addr_t SYS_CHANNEL_ADDR = 5'd1;

  localparam cmd_addr_t IO_MODE_ADDR   = 5'd0;
  localparam cmd_addr_t IO_LED_ADDR    = 5'd1;
  localparam cmd_addr_t IO_INPUTS_ADDR = 5'd2;   // Read only
  localparam cmd_addr_t IO_PMOD_ADDR   = 5'd3;

  localparam cmd_addr_t SMI_STATUS_ADDR = 5'd0;  // Read clears overflow

endpackage

`default_nettype wire

//--- hw/cariboulite_top.sv
`timescale 1ns/100ps
`default_nettype none

module cariboulite_top
  import cariboulite_pkg::*;
(
  input  logic                 i_glob_clock,
  input  logic                 i_rst_b,

  // Command bus from the host
  input  logic [NUM_PEERS-1:0] i_cmd_cs,       // 0 sys, 1 io, 2 smi, 3 reserved
  input  cmd_addr_t            i_cmd_addr,
  input  cmd_data_t            i_cmd_wdata,
  input  logic                 i_cmd_load,
  input  logic                 i_cmd_fetch,
  output cmd_data_t            o_cmd_rdata,

  // Assembled receive samples
  input  logic                 i_rx09_valid,
  input  sample_t              i_rx09_sample,
  input  logic                 i_rx24_valid,
  input  sample_t              i_rx24_sample,

  // SMI read side
  input  logic                 i_smi_soe,
  output logic [7:0]           o_smi_data,
  output logic                 o_smi_read_req,

  // Board I/O
  input  logic [3:0]           i_config,
  input  logic                 i_button,
  output logic                 o_led0,
  output logic                 o_led1,
  output logic [3:0]           o_pmod,

  // RF front end
  output logic                 o_rx_h_tx_l,
  output logic                 o_rx_h_tx_l_b,
  output logic                 o_tr_vc1,
  output logic                 o_tr_vc1_b,
  output logic                 o_tr_vc2,
  output logic                 o_shdn_rx_lna,
  output logic                 o_shdn_tx_lna
);

  logic    rx_channel;
  sample_t fifo_sample;
  logic    fifo_empty;
  logic    fifo_overflow;
  logic    fifo_pull;

  reg_bus_if sys_bus ();
  reg_bus_if io_bus ();
  reg_bus_if smi_bus ();

  reg_bus_mux reg_bus_mux_i (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .i_cmd_cs     (i_cmd_cs),
    .i_cmd_addr   (i_cmd_addr),
    .i_cmd_wdata  (i_cmd_wdata),
    .i_cmd_load   (i_cmd_load),
    .i_cmd_fetch  (i_cmd_fetch),
    .o_cmd_rdata  (o_cmd_rdata),
    .sys_bus      (sys_bus.ctrl),
    .io_bus       (io_bus.ctrl),
    .smi_bus      (smi_bus.ctrl)
  );

  sys_ctrl sys_ctrl_i (
    .i_glob_clock (i_glob_clock),
    .i_rst_b      (i_rst_b),
    .bus          (sys_bus.peer),
    .o_rx_channel (rx_channel)
  );

  io_ctrl io_ctrl_i (
    .i_glob_clock  (i_glob_clock),
    .i_rst_b       (i_rst_b),
    .bus           (io_bus.peer),
    .i_config      (i_config),
    .i_button      (i_button),
    .o_led0        (o_led0),
    .o_led1        (o_led1),
    .o_pmod        (o_pmod),
    .o_rx_h_tx_l   (o_rx_h_tx_l),
    .o_rx_h_tx_l_b (o_rx_h_tx_l_b),
    .o_tr_vc1      (o_tr_vc1),
    .o_tr_vc1_b    (o_tr_vc1_b),
    .o_tr_vc2      (o_tr_vc2),
    .o_shdn_rx_lna (o_shdn_rx_lna),
    .o_shdn_tx_lna (o_shdn_tx_lna)
  );

  rx_sample_fifo rx_sample_fifo_i (
    .i_glob_clock  (i_glob_clock),
    .i_rst_b       (i_rst_b),
    .i_rx_channel  (rx_channel),
    .i_rx09_valid  (i_rx09_valid),
    .i_rx09_sample (i_rx09_sample),
    .i_rx24_valid  (i_rx24_valid),
    .i_rx24_sample (i_rx24_sample),
    .i_pull        (fifo_pull),
    .o_sample      (fifo_sample),
    .o_empty       (fifo_empty),
    .o_overflow    (fifo_overflow)
  );

  smi_rx_reader smi_rx_reader_i (
    .i_glob_clock   (i_glob_clock),
    .i_rst_b        (i_rst_b),
    .bus            (smi_bus.peer),
    .i_sample       (fifo_sample),
    .i_empty        (fifo_empty),
    .i_overflow     (fifo_overflow),
    .i_smi_soe      (i_smi_soe),
    .o_pull         (fifo_pull),
    .o_smi_data     (o_smi_data),
    .o_smi_read_req (o_smi_read_req)
  );

endmodule

`default_nettype wire

//--- hw/io_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module io_ctrl
  import cariboulite_pkg::*;
(
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  reg_bus_if.peer    bus,
  input  logic [3:0] i_config,
  input  logic       i_button,
  output logic       o_led0,
  output logic       o_led1,
  output logic [3:0] o_pmod,
  output logic       o_rx_h_tx_l,
  output logic       o_rx_h_tx_l_b,
  output logic       o_tr_vc1,
  output logic       o_tr_vc1_b,
  output logic       o_tr_vc2,
  output logic       o_shdn_rx_lna,
  output logic       o_shdn_tx_lna
);

  rf_mode_e   mode;
  logic [1:0] led;
  logic [3:0] pmod;
  logic       is_rx;
  logic       is_tx;

  // ==========================================================================
  // Register writes
  // ==========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      mode <= LOW_POWER;
      led  <= '0;
      pmod <= '0;
    end else if (bus.load) begin
      case (bus.addr)
        IO_MODE_ADDR: begin
          if (bus.wdata[2:0] <= TX_24) begin   // Undefined codes dropped
            mode <= rf_mode_e'(bus.wdata[2:0]);
          end
        end
        IO_LED_ADDR:  led  <= bus.wdata[1:0];
        IO_PMOD_ADDR: pmod <= bus.wdata[3:0];
        default: ;                              // Inputs and holes are read only
      endcase
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      bus.rdata <= '0;
    end else if (bus.fetch) begin
      case (bus.addr)
        IO_MODE_ADDR:   bus.rdata <= {5'b0, mode};
        IO_LED_ADDR:    bus.rdata <= {6'b0, led};
        IO_INPUTS_ADDR: bus.rdata <= {3'b0, i_button, i_config};
        IO_PMOD_ADDR:   bus.rdata <= {4'b0, pmod};
        default:        bus.rdata <= '0;
      endcase
    end
  end

  // ==========================================================================
  // Front-end line decode
  // ==========================================================================
  assign is_rx = (mode == RX_09) || (mode == RX_24);
  assign is_tx = (mode == TX_09) || (mode == TX_24);

  assign o_rx_h_tx_l   = is_rx;                        // High selects receive path
  assign o_rx_h_tx_l_b = ~is_rx;
  assign o_tr_vc1      = (mode == RX_09) || (mode == TX_09);   // 0.9 GHz switch
  assign o_tr_vc1_b    = ~o_tr_vc1;
  assign o_tr_vc2      = (mode == RX_24) || (mode == TX_24);   // 2.4 GHz switch
  assign o_shdn_rx_lna = ~is_rx;                       // LNAs off unless in use
  assign o_shdn_tx_lna = ~is_tx;

  assign o_led0 = led[0];
  assign o_led1 = led[1];
  assign o_pmod = pmod;

endmodule

`default_nettype wire

//--- hw/reg_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

// One peer's slice of the command bus
interface reg_bus_if
  import cariboulite_pkg::*;
();

  cmd_addr_t addr;    // Register address, stable around strobes
  cmd_data_t wdata;   // Write byte
  logic      load;    // Write strobe, already gated by select
  logic      fetch;   // Read strobe, already gated by select
  cmd_data_t rdata;   // Registered answer from the peer

  modport ctrl (
    output addr,
    output wdata,
    output load,
    output fetch,
    input  rdata
  );

  modport peer (
    input  addr,
    input  wdata,
    input  load,
    input  fetch,
    output rdata
  );

endinterface

`default_nettype wire

//--- hw/reg_bus_mux.sv
`timescale 1ns/100ps
`default_nettype none

module reg_bus_mux
  import cariboulite_pkg::*;
(
  input  logic                 i_glob_clock,
  input  logic                 i_rst_b,
  input  logic [NUM_PEERS-1:0] i_cmd_cs,
  input  cmd_addr_t            i_cmd_addr,
  input  cmd_data_t            i_cmd_wdata,
  input  logic                 i_cmd_load,
  input  logic                 i_cmd_fetch,
  output cmd_data_t            o_cmd_rdata,
  reg_bus_if.ctrl              sys_bus,
  reg_bus_if.ctrl              io_bus,
  reg_bus_if.ctrl              smi_bus
);

  logic sel_sys;
  logic sel_io;
  logic sel_smi;
  logic sel_rsv;

  // Exactly one select bit set, anything else selects no peer
  assign sel_sys = (i_cmd_cs == NUM_PEERS'(1));
  assign sel_io  = (i_cmd_cs == NUM_PEERS'(2));
  assign sel_smi = (i_cmd_cs == NUM_PEERS'(4));
  assign sel_rsv = (i_cmd_cs == NUM_PEERS'(8));

  // Address and data go to every peer unchanged
  assign sys_bus.addr  = i_cmd_addr;
  assign sys_bus.wdata = i_cmd_wdata;
  assign io_bus.addr   = i_cmd_addr;
  assign io_bus.wdata  = i_cmd_wdata;
  assign smi_bus.addr  = i_cmd_addr;
  assign smi_bus.wdata = i_cmd_wdata;

  assign sys_bus.load  = i_cmd_load  & sel_sys;
  assign sys_bus.fetch = i_cmd_fetch & sel_sys;
  assign io_bus.load   = i_cmd_load  & sel_io;
  assign io_bus.fetch  = i_cmd_fetch & sel_io;
  assign smi_bus.load  = i_cmd_load  & sel_smi;
  assign smi_bus.fetch = i_cmd_fetch & sel_smi;

  // ==========================================================================
  // Read-back register, one edge behind the peer's own rdata
  // ==========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      o_cmd_rdata <= '0;
    end else if (sel_sys) begin
      o_cmd_rdata <= sys_bus.rdata;
    end else if (sel_io) begin
      o_cmd_rdata <= io_bus.rdata;
    end else if (sel_smi) begin
      o_cmd_rdata <= smi_bus.rdata;
    end else if (sel_rsv) begin
      o_cmd_rdata <= RESERVED_RDATA;
    end else if (i_cmd_cs == '0) begin
      o_cmd_rdata <= '0;                       // No module selected
    end
    // Multi-hot select keeps the last byte
  end

  // Host never issues a write and a read in the same cycle
  a_no_load_fetch : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    !(i_cmd_load && i_cmd_fetch));

endmodule

`default_nettype wire

//--- hw/rx_sample_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module rx_sample_fifo
  import cariboulite_pkg::*;
(
  input  logic    i_glob_clock,
  input  logic    i_rst_b,
  input  logic    i_rx_channel,
  input  logic    i_rx09_valid,
  input  sample_t i_rx09_sample,
  input  logic    i_rx24_valid,
  input  sample_t i_rx24_sample,
  input  logic    i_pull,
  output sample_t o_sample,          // Head of the FIFO, valid when not empty
  output logic    o_empty,
  output logic    o_overflow         // One-cycle pulse per dropped sample
);

  sample_t                         mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH):0]     count;
  logic                            in_valid;
  sample_t                         in_sample;
  logic                            full;
  logic                            push;

  // Channel select, the other stream is ignored
  assign in_valid  = i_rx_channel ? i_rx24_valid  : i_rx09_valid;
  assign in_sample = i_rx_channel ? i_rx24_sample : i_rx09_sample;

  assign full    = (count == FIFO_DEPTH);
  assign o_empty = (count == '0);
  assign push    = in_valid & ~full;

  // ==========================================================================
  // Storage and pointers
  // ==========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (push) begin
      mem[wr_ptr] <= in_sample;
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;             // Depth is a power of two
      end
      if (i_pull) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, i_pull})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                           // Both or neither
      endcase
      o_overflow <= in_valid & full;         // Sample lost
    end
  end

  assign o_sample = mem[rd_ptr];

  // Reader only pulls when a word is there
  a_no_pull_empty : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    i_pull |-> !o_empty);

endmodule

`default_nettype wire

//--- hw/smi_rx_reader.sv
`timescale 1ns/100ps
`default_nettype none

module smi_rx_reader
  import cariboulite_pkg::*;
(
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  reg_bus_if.peer    bus,
  input  sample_t    i_sample,
  input  logic       i_empty,
  input  logic       i_overflow,
  input  logic       i_smi_soe,
  output logic       o_pull,
  output logic [7:0] o_smi_data,
  output logic       o_smi_read_req
);

  sample_t                             word_buf;    // Word being sent
  logic                                word_valid;
  logic [$clog2(BYTES_PER_SAMPLE)-1:0] byte_idx;    // 0 is the MSB
  logic                                soe_q;
  logic                                soe_rise;
  logic                                ovf_flag;    // Sticky until status read
  logic                                last_byte;

  // ==========================================================================
  // Byte buffer and SMI strobe handling
  // ==========================================================================
  assign soe_rise  = i_smi_soe & ~soe_q;                     // Low then high
  assign last_byte = (byte_idx == BYTES_PER_SAMPLE - 1);
  assign o_pull    = ~word_valid & ~i_empty;                 // Refill when free

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      soe_q      <= 1'b1;                     // No false edge out of reset
      word_valid <= 1'b0;
      byte_idx   <= '0;
    end else begin
      soe_q <= i_smi_soe;
      if (o_pull) begin
        word_valid <= 1'b1;
        byte_idx   <= '0;
      end else if (word_valid && soe_rise) begin
        if (last_byte) begin
          word_valid <= 1'b0;                 // Whole word sent
          byte_idx   <= '0;
        end else begin
          byte_idx <= byte_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (o_pull) begin
      word_buf <= i_sample;
    end
  end

  // MSB first
  assign o_smi_data     = word_buf[(BYTES_PER_SAMPLE - 1 - byte_idx) * 8 +: 8];
  assign o_smi_read_req = word_valid;

  // ==========================================================================
  // Status register
  // ==========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      ovf_flag  <= 1'b0;
      bus.rdata <= '0;
    end else begin
      if (i_overflow) begin
        ovf_flag <= 1'b1;                     // New drop wins over the clear
      end else if (bus.fetch && bus.addr == SMI_STATUS_ADDR) begin
        ovf_flag <= 1'b0;
      end
      if (bus.fetch) begin
        if (bus.addr == SMI_STATUS_ADDR) begin
          bus.rdata <= {{(CMD_DATA_W-2){1'b0}}, ovf_flag, i_empty};
        end else begin
          bus.rdata <= '0;
        end
      end
    end
  end

  // Idle buffer always restarts at the MSB
  a_idle_byte_idx : assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    !word_valid |-> byte_idx == '0);

endmodule

`default_nettype wire

//--- hw/sys_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl
  import cariboulite_pkg::*;
(
  input  logic    i_glob_clock,
  input  logic    i_rst_b,
  reg_bus_if.peer bus,
  output logic    o_rx_channel         // 0 picks the 0.9 GHz stream
);

  logic channel;

  assign o_rx_channel = channel;

  // ==========================================================================
  // Register writes
  // ==========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      channel <= 1'b0;
    end else if (bus.load) begin
      if (bus.addr == SYS_CHANNEL_ADDR) begin
        channel <= bus.wdata[0];
      end
      // Version is read only
    end
  end

  // ==========================================================================
  // Fetch answers
  // ==========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      bus.rdata <= '0;
    end else if (bus.fetch) begin
      case (bus.addr)
        SYS_VERSION_ADDR: bus.rdata <= FW_VERSION;
        SYS_CHANNEL_ADDR: bus.rdata <= {{(CMD_DATA_W-1){1'b0}}, channel};
        default:          bus.rdata <= '0;   // Unassigned
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_cariboulite_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cariboulite_top
  import cariboulite_pkg::*;
();

  typedef enum logic [2:0] {
    OP_WRITE, OP_READ, OP_PUSH09, OP_PUSH24, OP_SMI_READ, OP_CHECK_RF, OP_CHECK_BOARD
  } op_e;

  // One step of the test; data is the write byte or a sample/word count
  typedef struct packed {
    op_e       op;
    logic [3:0] cs;
    cmd_addr_t addr;
    cmd_data_t data;
    cmd_data_t exp;      // Read byte, {7 RF lines} or {led1, led0, pmod}
  } row_t;

  localparam int NUM_ROWS       = 39;
  localparam int TIMEOUT_CYCLES = 8 + 200 * NUM_ROWS;   // Reset plus budget per row

  // RF lines packed as {rx_h_tx_l, rx_h_tx_l_b, vc1, vc1_b, vc2, shdn_rx, shdn_tx}
  row_t rows [NUM_ROWS] = '{
    '{OP_CHECK_RF,    4'h0, 5'd0,             8'h00, 8'h2B},  // Low power out of reset
    '{OP_READ,        4'h1, SYS_VERSION_ADDR, 8'h00, 8'h01},
    '{OP_READ,        4'h8, 5'd0,             8'h00, 8'hA5},  // Reserved select
    '{OP_READ,        4'h0, 5'd0,             8'h00, 8'h00},  // Nothing selected
    '{OP_READ,        4'h1, SYS_CHANNEL_ADDR, 8'h00, 8'h00},
    '{OP_WRITE,       4'h2, IO_MODE_ADDR,     8'h01, 8'h00},  // RX_09
    '{OP_CHECK_RF,    4'h0, 5'd0,             8'h00, 8'h51},
    '{OP_WRITE,       4'h2, IO_MODE_ADDR,     8'h02, 8'h00},  // TX_09
    '{OP_CHECK_RF,    4'h0, 5'd0,             8'h00, 8'h32},
    '{OP_WRITE,       4'h2, IO_MODE_ADDR,     8'h03, 8'h00},  // RX_24
    '{OP_CHECK_RF,    4'h0, 5'd0,             8'h00, 8'h4D},
    '{OP_WRITE,       4'h2, IO_MODE_ADDR,     8'h04, 8'h00},  // TX_24
    '{OP_CHECK_RF,    4'h0, 5'd0,             8'h00, 8'h2E},
    '{OP_WRITE,       4'h2, IO_MODE_ADDR,     8'h06, 8'h00},  // Undefined code
    '{OP_CHECK_RF,    4'h0, 5'd0,             8'h00, 8'h2E},
    '{OP_READ,        4'h2, IO_MODE_ADDR,     8'h00, 8'h04},
    '{OP_WRITE,       4'h2, IO_MODE_ADDR,     8'h00, 8'h00},
    '{OP_CHECK_RF,    4'h0, 5'd0,             8'h00, 8'h2B},
    '{OP_WRITE,       4'h2, IO_LED_ADDR,      8'hFE, 8'h00},  // Only bits 1:0 kept
    '{OP_WRITE,       4'h2, IO_PMOD_ADDR,     8'h5B, 8'h00},
    '{OP_CHECK_BOARD, 4'h0, 5'd0,             8'h00, 8'h2B},
    '{OP_READ,        4'h2, IO_INPUTS_ADDR,   8'h00, 8'h19},  // {button, config}
    '{OP_READ,        4'h3, 5'd0,             8'h00, 8'h19},  // Multi-hot holds byte
    '{OP_READ,        4'h2, 5'd9,             8'h00, 8'h00},  // Hole in the map
    '{OP_READ,        4'h4, SMI_STATUS_ADDR,  8'h00, 8'h01},  // Empty, no overflow
    '{OP_PUSH09,      4'h0, 5'd0,             8'd3,  8'h00},
    '{OP_PUSH24,      4'h0, 5'd0,             8'd3,  8'h00},  // Ignored on channel 0
    '{OP_SMI_READ,    4'h0, 5'd0,             8'd3,  8'h00},
    '{OP_WRITE,       4'h1, SYS_CHANNEL_ADDR, 8'h01, 8'h00},
    '{OP_READ,        4'h1, SYS_CHANNEL_ADDR, 8'h00, 8'h01},
    '{OP_PUSH24,      4'h0, 5'd0,             8'd4,  8'h00},
    '{OP_PUSH09,      4'h0, 5'd0,             8'd2,  8'h00},  // Ignored on channel 1
    '{OP_SMI_READ,    4'h0, 5'd0,             8'd4,  8'h00},
    '{OP_WRITE,       4'h1, SYS_CHANNEL_ADDR, 8'h00, 8'h00},
    '{OP_PUSH09,      4'h0, 5'd0,             8'd19, 8'h00},  // Depth plus 3
    '{OP_READ,        4'h4, SMI_STATUS_ADDR,  8'h00, 8'h02},  // Overflow, not empty
    '{OP_SMI_READ,    4'h0, 5'd0,             8'd17, 8'h00},  // Depth plus reader word
    '{OP_READ,        4'h4, SMI_STATUS_ADDR,  8'h00, 8'h01},  // Flag cleared by fetch
    '{OP_CHECK_RF,    4'h0, 5'd0,             8'h00, 8'h2B}
  };

  logic       glob_clock;
  logic       rst_b;
  logic [3:0] cmd_cs;
  cmd_addr_t  cmd_addr;
  cmd_data_t  cmd_wdata;
  logic       cmd_load;
  logic       cmd_fetch;
  cmd_data_t  cmd_rdata;
  logic       rx09_valid;
  sample_t    rx09_sample;
  logic       rx24_valid;
  sample_t    rx24_sample;
  logic       smi_soe;
  logic [7:0] smi_data;
  logic       smi_read_req;
  logic [3:0] config_in;
  logic       button;
  logic       led0;
  logic       led1;
  logic [3:0] pmod;
  logic       rx_h_tx_l;
  logic       rx_h_tx_l_b;
  logic       tr_vc1;
  logic       tr_vc1_b;
  logic       tr_vc2;
  logic       shdn_rx_lna;
  logic       shdn_tx_lna;

  sample_t     model_q [$];      // FIFO plus reader buffer
  logic        model_channel;    // Tracks writes to the channel register
  int          row_idx;
  int          cycle_count = 0;

  cariboulite_top dut_i (
    .i_glob_clock   (glob_clock),
    .i_rst_b        (rst_b),
    .i_cmd_cs       (cmd_cs),
    .i_cmd_addr     (cmd_addr),
    .i_cmd_wdata    (cmd_wdata),
    .i_cmd_load     (cmd_load),
    .i_cmd_fetch    (cmd_fetch),
    .o_cmd_rdata    (cmd_rdata),
    .i_rx09_valid   (rx09_valid),
    .i_rx09_sample  (rx09_sample),
    .i_rx24_valid   (rx24_valid),
    .i_rx24_sample  (rx24_sample),
    .i_smi_soe      (smi_soe),
    .o_smi_data     (smi_data),
    .o_smi_read_req (smi_read_req),
    .i_config       (config_in),
    .i_button       (button),
    .o_led0         (led0),
    .o_led1         (led1),
    .o_pmod         (pmod),
    .o_rx_h_tx_l    (rx_h_tx_l),
    .o_rx_h_tx_l_b  (rx_h_tx_l_b),
    .o_tr_vc1       (tr_vc1),
    .o_tr_vc1_b     (tr_vc1_b),
    .o_tr_vc2       (tr_vc2),
    .o_shdn_rx_lna  (shdn_rx_lna),
    .o_shdn_tx_lna  (shdn_tx_lna)
  );

  always #20 glob_clock = ~glob_clock;   // 40 ns period

  // Watchdog
  always @(posedge glob_clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_run($sformatf("Timeout: run still busy after %0d cycles, at table row %0d",
                         cycle_count, row_idx));
    end
  end

  // ==========================================================================
  // Result checks
  // ==========================================================================
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string what, input cmd_data_t got, input cmd_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t: row %0d %s got %02h expected %02h",
                         $time, row_idx, what, got, exp));
    end
  endtask

  task automatic check_sample(input string what, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %0t: row %0d %s got I=%04h Q=%04h expected I=%04h Q=%04h",
                         $time, row_idx, what, got.i, got.q, exp.i, exp.q));
    end
  endtask

  task automatic check_rf(input cmd_data_t exp);
    logic [6:0] got;
    got = {rx_h_tx_l, rx_h_tx_l_b, tr_vc1, tr_vc1_b, tr_vc2, shdn_rx_lna, shdn_tx_lna};
    if (got !== exp[6:0]) begin
      stop_run($sformatf("ERR %0t: row %0d RF lines got %07b expected %07b",
                         $time, row_idx, got, exp[6:0]));
    end
  endtask

  task automatic check_board(input cmd_data_t exp);
    logic [5:0] got;
    got = {led1, led0, pmod};
    if (got !== exp[5:0]) begin
      stop_run($sformatf("ERR %0t: row %0d LED/pmod got %06b expected %06b",
                         $time, row_idx, got, exp[5:0]));
    end
  endtask

  // ==========================================================================
  // Bus and stream drivers
  // ==========================================================================
  task automatic write_reg(input logic [3:0] cs, input cmd_addr_t addr, input cmd_data_t data);
    @(posedge glob_clock);
    cmd_cs    <= cs;
    cmd_addr  <= addr;
    cmd_wdata <= data;
    cmd_load  <= 1'b1;
    @(posedge glob_clock);                 // Write lands on this edge
    cmd_load  <= 1'b0;
    if (cs == 4'b0001 && addr == SYS_CHANNEL_ADDR) begin
      model_channel = data[0];
    end
  endtask

  task automatic read_reg(input logic [3:0] cs, input cmd_addr_t addr, input cmd_data_t exp);
    @(posedge glob_clock);
    cmd_cs    <= cs;
    cmd_addr  <= addr;
    cmd_fetch <= 1'b1;
    @(posedge glob_clock);                 // Peer registers its byte
    cmd_fetch <= 1'b0;
    @(posedge glob_clock);                 // Mux registers the selected byte
    @(negedge glob_clock);
    check_byte("register read", cmd_rdata, exp);
  endtask

  task automatic push_samples(input logic stream24, input int count);
    sample_t s;
    for (int k = 0; k < count; k++) begin
      s = sample_t'($urandom);
      @(posedge glob_clock);
      if (stream24) begin
        rx24_valid  <= 1'b1;
        rx24_sample <= s;
      end else begin
        rx09_valid  <= 1'b1;
        rx09_sample <= s;
      end
      // Model keeps only the selected stream up to its capacity
      if (stream24 == model_channel && model_q.size() < FIFO_DEPTH + 1) begin
        model_q.push_back(s);
      end
    end
    @(posedge glob_clock);
    rx09_valid <= 1'b0;
    rx24_valid <= 1'b0;
  endtask

  task automatic read_smi_words(input int count);
    sample_t     exp_w;
    logic [31:0] got_bits;
    @(negedge glob_clock);
    for (int w = 0; w < count; w++) begin
      if (model_q.size() == 0) begin
        stop_run("Test table asks for more SMI words than were kept");
      end
      exp_w = model_q.pop_front();
      while (!smi_read_req) @(negedge glob_clock);   // Reader loads next word
      for (int b = 0; b < BYTES_PER_SAMPLE; b++) begin
        got_bits = {got_bits[23:0], smi_data};       // Bytes collected MSB first
        @(posedge glob_clock);
        smi_soe <= 1'b0;
        @(posedge glob_clock);             // Low strobe sampled here
        smi_soe <= 1'b1;
        @(negedge glob_clock);
        check_byte("SMI byte while strobe low", smi_data, got_bits[7:0]);
        @(posedge glob_clock);             // Rising strobe advances the byte
        @(negedge glob_clock);
      end
      check_sample("SMI word", sample_t'(got_bits), exp_w);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    void'($urandom(32'h3287));             // Seed the generator once
    glob_clock    = 1'b0;
    rst_b         <= 1'b0;
    cmd_cs        <= '0;
    cmd_addr      <= '0;
    cmd_wdata     <= '0;
    cmd_load      <= 1'b0;
    cmd_fetch     <= 1'b0;
    rx09_valid    <= 1'b0;
    rx09_sample   <= '0;
    rx24_valid    <= 1'b0;
    rx24_sample   <= '0;
    smi_soe       <= 1'b1;                 // Idle high, edges come as low then high
    config_in     <= 4'b1001;
    button        <= 1'b1;
    model_channel = 1'b0;
    row_idx       = -1;

    repeat (8) @(posedge glob_clock);
    rst_b <= 1'b1;
    @(negedge glob_clock);
    check_byte("rdata after reset", cmd_rdata, 8'h00);
    check_byte("read request after reset", cmd_data_t'(smi_read_req), 8'h00);

    for (int r = 0; r < NUM_ROWS; r++) begin
      row_idx = r;
      case (rows[r].op)
        OP_WRITE:       write_reg(rows[r].cs, rows[r].addr, rows[r].data);
        OP_READ:        read_reg(rows[r].cs, rows[r].addr, rows[r].exp);
        OP_PUSH09:      push_samples(1'b0, int'(rows[r].data));
        OP_PUSH24:      push_samples(1'b1, int'(rows[r].data));
        OP_SMI_READ:    read_smi_words(int'(rows[r].data));
        OP_CHECK_RF: begin
          @(negedge glob_clock);
          check_rf(rows[r].exp);
        end
        OP_CHECK_BOARD: begin
          @(negedge glob_clock);
          check_board(rows[r].exp);
        end
        default:        stop_run("Unknown operation in test table");
      endcase
    end

    @(posedge glob_clock);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
